/* source/dual_pkg.sv */
package dual_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam int reg_count = 32;
	localparam word_t nop_word = 32'h0000_0000;

	// primary opcodes
	localparam logic [5:0] opc_special = 6'h00;
	localparam logic [5:0] opc_addiu = 6'h09;
	localparam logic [5:0] opc_ori = 6'h0d;
	localparam logic [5:0] opc_lui = 6'h0f;

	// function field of special
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_xor = 6'h26;
	localparam logic [5:0] fn_slt = 6'h2a;

	typedef enum logic [3:0] {
		op_nop,
		op_addu,
		op_subu,
		op_and,
		op_or,
		op_xor,
		op_slt,
		op_addiu,
		op_ori,
		op_lui
	} alu_op_e;

	typedef struct packed {
		alu_op_e op;
		reg_addr_t src_a;
		reg_addr_t src_b;
		logic uses_src_b;
		reg_addr_t dest;
		logic writes;
		logic [15:0] imm;
	} decoded_t;

	typedef struct packed {
		logic we;
		reg_addr_t addr;
		word_t wdata;
	} reg_write_t;

endpackage

/* source/issue_if.sv */
`timescale 1ns/10ps

interface issue_if;

	logic valid;
	dual_pkg::alu_op_e op;
	dual_pkg::reg_addr_t dest;
	logic writes;
	dual_pkg::word_t opnd_a;
	// register value or extended immediate
	dual_pkg::word_t opnd_b;

	modport issuer (
		output valid,
		output op,
		output dest,
		output writes,
		output opnd_a,
		output opnd_b
	);

	modport lane (
		input valid,
		input op,
		input dest,
		input writes,
		input opnd_a,
		input opnd_b
	);

endinterface

/* source/inst_decoder.sv */
`timescale 1ns/10ps

module inst_decoder (
	input  dual_pkg::word_t    inst,
	output dual_pkg::decoded_t dec
);

	logic [5:0] opcode;
	logic [5:0] funct;
	dual_pkg::reg_addr_t rs;
	dual_pkg::reg_addr_t rt;
	dual_pkg::reg_addr_t rd;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];
	assign rs = inst[25:21];
	assign rt = inst[20:16];
	assign rd = inst[15:11];

	always_comb
	begin
		dec.op = dual_pkg::op_nop;
		dec.src_a = rs;
		dec.src_b = rt;
		dec.uses_src_b = 1'b0;
		dec.dest = rt;
		dec.imm = inst[15:0];
		case (opcode)
			dual_pkg::opc_special:
			begin
				dec.uses_src_b = 1'b1;
				dec.dest = rd;
				case (funct)
					dual_pkg::fn_addu: dec.op = dual_pkg::op_addu;
					dual_pkg::fn_subu: dec.op = dual_pkg::op_subu;
					dual_pkg::fn_and: dec.op = dual_pkg::op_and;
					dual_pkg::fn_or: dec.op = dual_pkg::op_or;
					dual_pkg::fn_xor: dec.op = dual_pkg::op_xor;
					dual_pkg::fn_slt: dec.op = dual_pkg::op_slt;
					default: dec.op = dual_pkg::op_nop;
				endcase
			end
			dual_pkg::opc_addiu: dec.op = dual_pkg::op_addiu;
			dual_pkg::opc_ori: dec.op = dual_pkg::op_ori;
			dual_pkg::opc_lui: dec.op = dual_pkg::op_lui;
			default: dec.op = dual_pkg::op_nop;
		endcase

		// lui and no-ops read no register, so they never cause a hold
		if (dec.op == dual_pkg::op_nop || dec.op == dual_pkg::op_lui)
		begin
			dec.src_a = '0;
		end
		if (dec.op == dual_pkg::op_nop)
		begin
			dec.uses_src_b = 1'b0;
		end

		dec.writes = (dec.op != dual_pkg::op_nop) && (dec.dest != '0);
	end

endmodule

/* source/gpr_file.sv */
`timescale 1ns/10ps

module gpr_file (
	input  logic                   clk,
	input  logic                   arst_n,
	input  dual_pkg::reg_write_t   wr_a,
	input  dual_pkg::reg_write_t   wr_b,
	input  dual_pkg::reg_addr_t    raddr1,
	input  dual_pkg::reg_addr_t    raddr2,
	input  dual_pkg::reg_addr_t    raddr3,
	input  dual_pkg::reg_addr_t    raddr4,
	output dual_pkg::word_t        rdata1,
	output dual_pkg::word_t        rdata2,
	output dual_pkg::word_t        rdata3,
	output dual_pkg::word_t        rdata4
);

	dual_pkg::word_t regs [dual_pkg::reg_count];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < dual_pkg::reg_count; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			if (wr_a.we && wr_a.addr != '0)
				regs[wr_a.addr] <= wr_a.wdata;
			// lane b is younger, its write lands last
			if (wr_b.we && wr_b.addr != '0)
				regs[wr_b.addr] <= wr_b.wdata;
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
	assign rdata3 = (raddr3 == '0) ? '0 : regs[raddr3];
	assign rdata4 = (raddr4 == '0) ? '0 : regs[raddr4];

endmodule

/* source/pair_issue.sv */
`timescale 1ns/10ps

module pair_issue (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                pair_valid,
	output logic                pair_ready,
	input  dual_pkg::word_t     inst_a,
	input  dual_pkg::word_t     inst_b,
	output dual_pkg::reg_addr_t raddr1,
	output dual_pkg::reg_addr_t raddr2,
	output dual_pkg::reg_addr_t raddr3,
	output dual_pkg::reg_addr_t raddr4,
	input  dual_pkg::word_t     rdata1,
	input  dual_pkg::word_t     rdata2,
	input  dual_pkg::word_t     rdata3,
	input  dual_pkg::word_t     rdata4,
	issue_if.issuer             lane_a_bus,
	issue_if.issuer             lane_b_bus
);

	logic accept;
	logic pair_full;
	logic left_full;
	logic hold;
	logic b_reads_dest;
	logic b_same_dest;
	dual_pkg::word_t pair_inst_a;
	dual_pkg::word_t pair_inst_b;
	dual_pkg::decoded_t dec_a;
	dual_pkg::decoded_t dec_b;
	dual_pkg::decoded_t left_dec;
	dual_pkg::decoded_t slot_a;

	function automatic dual_pkg::word_t operand_b(input dual_pkg::decoded_t dec,
		input dual_pkg::word_t rdata);
		dual_pkg::word_t opnd;
		if (dec.uses_src_b)
			opnd = rdata;
		else
		begin
			case (dec.op)
				dual_pkg::op_addiu: opnd = {{16{dec.imm[15]}}, dec.imm};
				dual_pkg::op_lui: opnd = {dec.imm, 16'h0000};
				default: opnd = {16'h0000, dec.imm};
			endcase
		end
		return opnd;
	endfunction

	inst_decoder dec_a_inst (.inst(pair_inst_a), .dec(dec_a));
	inst_decoder dec_b_inst (.inst(pair_inst_b), .dec(dec_b));

	// pairing check against the older instruction's dest
	assign b_reads_dest = (dec_b.src_a == dec_a.dest) ||
		(dec_b.uses_src_b && dec_b.src_b == dec_a.dest);
	assign b_same_dest = dec_b.writes && (dec_b.dest == dec_a.dest);
	assign hold = pair_full && dec_a.writes && (b_reads_dest || b_same_dest);

	assign pair_ready = ~hold;
	assign accept = pair_valid & pair_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pair_full <= 1'b0;
			left_full <= 1'b0;
		end
		else
		begin
			pair_full <= accept;
			left_full <= hold;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			pair_inst_a <= inst_a;
			pair_inst_b <= inst_b;
		end
		if (hold)
			left_dec <= dec_b;
	end

	// held instruction goes alone through lane a
	assign slot_a = left_full ? left_dec : dec_a;

	assign raddr1 = slot_a.src_a;
	assign raddr2 = slot_a.src_b;
	assign raddr3 = dec_b.src_a;
	assign raddr4 = dec_b.src_b;

	assign lane_a_bus.valid = left_full | pair_full;
	assign lane_a_bus.op = slot_a.op;
	assign lane_a_bus.dest = slot_a.dest;
	assign lane_a_bus.writes = slot_a.writes;
	assign lane_a_bus.opnd_a = rdata1;
	assign lane_a_bus.opnd_b = operand_b(slot_a, rdata2);

	assign lane_b_bus.valid = pair_full & ~hold;
	assign lane_b_bus.op = dec_b.op;
	assign lane_b_bus.dest = dec_b.dest;
	assign lane_b_bus.writes = dec_b.writes;
	assign lane_b_bus.opnd_a = rdata3;
	assign lane_b_bus.opnd_b = operand_b(dec_b, rdata4);

endmodule

/* source/alu_lane.sv */
`timescale 1ns/10ps

module alu_lane (
	input  logic                 clk,
	input  logic                 arst_n,
	issue_if.lane                issue,
	output dual_pkg::reg_write_t wr,
	output logic                 retire_valid,
	output dual_pkg::reg_addr_t  retire_addr,
	output dual_pkg::word_t      retire_data
);

	dual_pkg::word_t result;

	always_comb
	begin
		case (issue.op)
			dual_pkg::op_addu,
			dual_pkg::op_addiu: result = issue.opnd_a + issue.opnd_b;
			dual_pkg::op_subu: result = issue.opnd_a - issue.opnd_b;
			dual_pkg::op_and: result = issue.opnd_a & issue.opnd_b;
			dual_pkg::op_or,
			dual_pkg::op_ori: result = issue.opnd_a | issue.opnd_b;
			dual_pkg::op_xor: result = issue.opnd_a ^ issue.opnd_b;
			dual_pkg::op_slt: result = {31'b0, $signed(issue.opnd_a) < $signed(issue.opnd_b)};
			// immediate already shifted up by the issue unit
			dual_pkg::op_lui: result = issue.opnd_b;
			default: result = '0;
		endcase
	end

	assign wr = '{we: issue.valid & issue.writes, addr: issue.dest, wdata: result};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			retire_valid <= 1'b0;
		else
			retire_valid <= wr.we;
	end

	// retire report captured on the same edge as the register write
	always_ff @(posedge clk)
	begin
		if (wr.we)
		begin
			retire_addr <= wr.addr;
			retire_data <= wr.wdata;
		end
	end

endmodule

/* source/dual_issue_core.sv */
`timescale 1ns/10ps

module dual_issue_core (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                pair_valid,
	output logic                pair_ready,
	input  dual_pkg::word_t     inst_a,
	input  dual_pkg::word_t     inst_b,
	output logic                retire_valid_a,
	output dual_pkg::reg_addr_t retire_addr_a,
	output dual_pkg::word_t     retire_data_a,
	output logic                retire_valid_b,
	output dual_pkg::reg_addr_t retire_addr_b,
	output dual_pkg::word_t     retire_data_b
);

	dual_pkg::reg_addr_t raddr1;
	dual_pkg::reg_addr_t raddr2;
	dual_pkg::reg_addr_t raddr3;
	dual_pkg::reg_addr_t raddr4;
	dual_pkg::word_t rdata1;
	dual_pkg::word_t rdata2;
	dual_pkg::word_t rdata3;
	dual_pkg::word_t rdata4;
	dual_pkg::reg_write_t wr_a;
	dual_pkg::reg_write_t wr_b;

	issue_if lane_a_bus ();
	issue_if lane_b_bus ();

	pair_issue issue0 (
		.clk, .arst_n,
		.pair_valid, .pair_ready, .inst_a, .inst_b,
		.raddr1, .raddr2, .raddr3, .raddr4,
		.rdata1, .rdata2, .rdata3, .rdata4,
		.lane_a_bus, .lane_b_bus
	);

	gpr_file gpr0 (
		.clk, .arst_n,
		.wr_a, .wr_b,
		.raddr1, .raddr2, .raddr3, .raddr4,
		.rdata1, .rdata2, .rdata3, .rdata4
	);

	// lane a always holds the older instruction
	alu_lane lane_a (
		.clk, .arst_n, .issue(lane_a_bus), .wr(wr_a),
		.retire_valid(retire_valid_a), .retire_addr(retire_addr_a), .retire_data(retire_data_a)
	);

	alu_lane lane_b (
		.clk, .arst_n, .issue(lane_b_bus), .wr(wr_b),
		.retire_valid(retire_valid_b), .retire_addr(retire_addr_b), .retire_data(retire_data_b)
	);

endmodule

/* verification/dual_issue_assert.sv */
`timescale 1ns/10ps

module dual_issue_assert (
	input logic clk,
	input logic arst_n,
	input logic pair_valid,
	input logic pair_ready,
	input logic retire_valid_a,
	input logic retire_valid_b
);

	int fail_count = 0;

	ready_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> pair_ready)
	else
	begin
		fail_count++;
		$error("pair_ready low in the first cycle after reset release");
	end

	// a hold lasts one cycle only
	ready_low_once: assert property (@(posedge clk) disable iff (!arst_n)
		!pair_ready |=> pair_ready)
	else
	begin
		fail_count++;
		$error("pair_ready low for more than one cycle");
	end

	ready_drop_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(pair_ready) |-> $past(pair_valid && pair_ready))
	else
	begin
		fail_count++;
		$error("pair_ready dropped without an accepted pair");
	end

	lane_b_with_a: assert property (@(posedge clk) disable iff (!arst_n)
		retire_valid_b |-> retire_valid_a)
	else
	begin
		fail_count++;
		$error("retire_valid_b high without retire_valid_a");
	end

endmodule

bind dual_issue_core dual_issue_assert checks0 (.*);

/* verification/tb_dual_issue.sv */
`timescale 1ns/10ps

module tb_dual_issue;

	typedef struct packed {
		dual_pkg::word_t inst_a;
		dual_pkg::word_t inst_b;
		logic hold;
		dual_pkg::reg_addr_t addr_a;
		dual_pkg::word_t data_a;
		dual_pkg::reg_addr_t addr_b;
		dual_pkg::word_t data_b;
	} pair_vec_t;

	localparam int directed_count = 12;
	localparam int random_count = 200;
	localparam int wait_limit = 10;

	logic clk;
	logic arst_n;
	logic pair_valid;
	logic pair_ready;
	dual_pkg::word_t inst_a;
	dual_pkg::word_t inst_b;
	logic retire_valid_a;
	dual_pkg::reg_addr_t retire_addr_a;
	dual_pkg::word_t retire_data_a;
	logic retire_valid_b;
	dual_pkg::reg_addr_t retire_addr_b;
	dual_pkg::word_t retire_data_b;

	pair_vec_t directed [directed_count];
	pair_vec_t vec;
	dual_pkg::word_t ref_regs [dual_pkg::reg_count];
	integer seed = 32'ha8ec5db9;
	int idx;
	int check_count = 0;
	int error_count = 0;
	int timeout_count = 0;

	dual_issue_core dut0 (
		.clk, .arst_n,
		.pair_valid, .pair_ready, .inst_a, .inst_b,
		.retire_valid_a, .retire_addr_a, .retire_data_a,
		.retire_valid_b, .retire_addr_b, .retire_data_b
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_word(input string what, input dual_pkg::word_t got,
		input dual_pkg::word_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp, got);
		end
	endtask

	task automatic check_addr(input string what, input dual_pkg::reg_addr_t got,
		input dual_pkg::reg_addr_t exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t: %s expected r%0d, got r%0d", $time, what, exp, got);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("[ERROR] %0t: %s expected %b, got %b", $time, what, exp, got);
		end
	endtask

	// MIPS encoding, rt is the dest for immediate forms
	function automatic dual_pkg::word_t inst_word(input dual_pkg::alu_op_e op,
		input dual_pkg::reg_addr_t rs, input dual_pkg::reg_addr_t rt,
		input dual_pkg::reg_addr_t dest, input logic [15:0] imm);
		logic [5:0] fn;
		dual_pkg::word_t w;
		case (op)
			dual_pkg::op_subu: fn = dual_pkg::fn_subu;
			dual_pkg::op_and: fn = dual_pkg::fn_and;
			dual_pkg::op_or: fn = dual_pkg::fn_or;
			dual_pkg::op_xor: fn = dual_pkg::fn_xor;
			dual_pkg::op_slt: fn = dual_pkg::fn_slt;
			default: fn = dual_pkg::fn_addu;
		endcase
		case (op)
			dual_pkg::op_addiu: w = {dual_pkg::opc_addiu, rs, dest, imm};
			dual_pkg::op_ori: w = {dual_pkg::opc_ori, rs, dest, imm};
			dual_pkg::op_lui: w = {dual_pkg::opc_lui, 5'd0, dest, imm};
			default: w = {dual_pkg::opc_special, rs, rt, dest, 5'd0, fn};
		endcase
		return w;
	endfunction

	function automatic dual_pkg::word_t ref_result(input dual_pkg::alu_op_e op,
		input dual_pkg::word_t va, input dual_pkg::word_t vb, input logic [15:0] imm);
		dual_pkg::word_t r;
		case (op)
			dual_pkg::op_addu: r = va + vb;
			dual_pkg::op_subu: r = va - vb;
			dual_pkg::op_and: r = va & vb;
			dual_pkg::op_or: r = va | vb;
			dual_pkg::op_xor: r = va ^ vb;
			dual_pkg::op_slt: r = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
			dual_pkg::op_addiu: r = va + {{16{imm[15]}}, imm};
			dual_pkg::op_ori: r = va | {16'h0000, imm};
			dual_pkg::op_lui: r = {imm, 16'h0000};
			default: r = '0;
		endcase
		return r;
	endfunction

	// registers r0..r7 only, so dependences come up often
	function automatic dual_pkg::reg_addr_t small_reg(input int base);
		int pick;
		pick = base + ($unsigned($random(seed)) % (8 - base));
		return pick[4:0];
	endfunction

	function automatic dual_pkg::alu_op_e random_op();
		int pick;
		pick = 1 + ($unsigned($random(seed)) % 9);
		return dual_pkg::alu_op_e'(pick[3:0]);
	endfunction

	task automatic build_table();
		directed[0] = '{inst_word(dual_pkg::op_addiu, 5'd0, 5'd0, 5'd1, 16'h0005),
			inst_word(dual_pkg::op_lui, 5'd0, 5'd0, 5'd2, 16'h8000),
			1'b0, 5'd1, 32'h0000_0005, 5'd2, 32'h8000_0000};
		directed[1] = '{inst_word(dual_pkg::op_addiu, 5'd0, 5'd0, 5'd3, 16'hfffd),
			inst_word(dual_pkg::op_ori, 5'd0, 5'd0, 5'd4, 16'hf0f0),
			1'b0, 5'd3, 32'hffff_fffd, 5'd4, 32'h0000_f0f0};
		directed[2] = '{inst_word(dual_pkg::op_addu, 5'd1, 5'd3, 5'd5, 16'h0000),
			inst_word(dual_pkg::op_subu, 5'd1, 5'd3, 5'd6, 16'h0000),
			1'b0, 5'd5, 32'h0000_0002, 5'd6, 32'h0000_0008};
		directed[3] = '{inst_word(dual_pkg::op_and, 5'd3, 5'd4, 5'd7, 16'h0000),
			inst_word(dual_pkg::op_or, 5'd1, 5'd2, 5'd8, 16'h0000),
			1'b0, 5'd7, 32'h0000_f0f0, 5'd8, 32'h8000_0005};
		directed[4] = '{inst_word(dual_pkg::op_xor, 5'd3, 5'd4, 5'd9, 16'h0000),
			inst_word(dual_pkg::op_slt, 5'd3, 5'd1, 5'd10, 16'h0000),
			1'b0, 5'd9, 32'hffff_0f0d, 5'd10, 32'h0000_0001};
		directed[5] = '{inst_word(dual_pkg::op_slt, 5'd1, 5'd2, 5'd11, 16'h0000),
			inst_word(dual_pkg::op_ori, 5'd2, 5'd0, 5'd12, 16'h1234),
			1'b0, 5'd11, 32'h0000_0000, 5'd12, 32'h8000_1234};
		// raw on src_a, same dest, raw on src_b
		directed[6] = '{inst_word(dual_pkg::op_addiu, 5'd1, 5'd0, 5'd13, 16'h0010),
			inst_word(dual_pkg::op_addu, 5'd13, 5'd1, 5'd14, 16'h0000),
			1'b1, 5'd13, 32'h0000_0015, 5'd14, 32'h0000_001a};
		directed[7] = '{inst_word(dual_pkg::op_ori, 5'd0, 5'd0, 5'd15, 16'h00aa),
			inst_word(dual_pkg::op_addiu, 5'd0, 5'd0, 5'd15, 16'h0055),
			1'b1, 5'd15, 32'h0000_00aa, 5'd15, 32'h0000_0055};
		directed[8] = '{inst_word(dual_pkg::op_lui, 5'd0, 5'd0, 5'd16, 16'h1234),
			inst_word(dual_pkg::op_subu, 5'd4, 5'd16, 5'd17, 16'h0000),
			1'b1, 5'd16, 32'h1234_0000, 5'd17, 32'hedcc_f0f0};
		// no retire for r0 writes and no-ops
		directed[9] = '{inst_word(dual_pkg::op_addu, 5'd1, 5'd2, 5'd0, 16'h0000),
			dual_pkg::nop_word, 1'b0, 5'd0, 32'h0, 5'd0, 32'h0};
		directed[10] = '{inst_word(dual_pkg::op_addiu, 5'd0, 5'd0, 5'd18, 16'h0007),
			32'h0022_983f, 1'b0, 5'd18, 32'h0000_0007, 5'd0, 32'h0};
		directed[11] = '{inst_word(dual_pkg::op_addu, 5'd0, 5'd0, 5'd19, 16'h0000),
			inst_word(dual_pkg::op_or, 5'd0, 5'd1, 5'd20, 16'h0000),
			1'b0, 5'd19, 32'h0000_0000, 5'd20, 32'h0000_0005};
	endtask

	task automatic commit_expected(input pair_vec_t v);
		if (v.addr_a != '0)
			ref_regs[v.addr_a] = v.data_a;
		if (v.addr_b != '0)
			ref_regs[v.addr_b] = v.data_b;
	endtask

	// inst_a always writes a nonzero register, so lane b never retires alone
	task automatic random_pair(output pair_vec_t v);
		dual_pkg::alu_op_e op_a;
		dual_pkg::alu_op_e op_b;
		dual_pkg::reg_addr_t rs_a;
		dual_pkg::reg_addr_t rt_a;
		dual_pkg::reg_addr_t dest_a;
		dual_pkg::reg_addr_t rs_b;
		dual_pkg::reg_addr_t rt_b;
		dual_pkg::reg_addr_t dest_b;
		logic [15:0] imm_a;
		logic [15:0] imm_b;
		logic hold;
		dual_pkg::word_t res_a;
		dual_pkg::word_t res_b;
		op_a = random_op();
		op_b = random_op();
		rs_a = (op_a == dual_pkg::op_lui) ? 5'd0 : small_reg(0);
		rt_a = small_reg(0);
		dest_a = small_reg(1);
		rs_b = (op_b == dual_pkg::op_lui) ? 5'd0 : small_reg(0);
		rt_b = small_reg(0);
		dest_b = small_reg(0);
		imm_a = 16'($random(seed));
		imm_b = 16'($random(seed));
		hold = (rs_b == dest_a) || (dest_b == dest_a) ||
			(op_b <= dual_pkg::op_slt && rt_b == dest_a);
		res_a = ref_result(op_a, ref_regs[rs_a], ref_regs[rt_a], imm_a);
		ref_regs[dest_a] = res_a;
		res_b = ref_result(op_b, ref_regs[rs_b], ref_regs[rt_b], imm_b);
		if (dest_b != '0)
			ref_regs[dest_b] = res_b;
		v = '{inst_word(op_a, rs_a, rt_a, dest_a, imm_a),
			inst_word(op_b, rs_b, rt_b, dest_b, imm_b),
			hold, dest_a, res_a, dest_b, res_b};
	endtask

	task automatic check_retire(input string lane, input logic valid, input logic exp_valid,
		input dual_pkg::reg_addr_t addr, input dual_pkg::reg_addr_t exp_addr,
		input dual_pkg::word_t data, input dual_pkg::word_t exp_data);
		check_flag({lane, " valid"}, valid, exp_valid);
		if (exp_valid)
		begin
			check_addr({lane, " addr"}, addr, exp_addr);
			check_word({lane, " data"}, data, exp_data);
		end
	endtask

	task automatic apply_pair(input pair_vec_t v);
		int waited;
		@(posedge clk);
		pair_valid <= 1'b1;
		inst_a <= v.inst_a;
		inst_b <= v.inst_b;
		waited = 0;
		@(negedge clk);
		while (!pair_ready && waited < wait_limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (!pair_ready)
		begin
			timeout_count++;
			$display("timeout: pair_ready stayed low, the pair was never accepted");
			@(posedge clk);
			pair_valid <= 1'b0;
		end
		else
		begin
			// acceptance edge
			@(posedge clk);
			pair_valid <= 1'b0;
			@(negedge clk);
			check_flag("pair_ready while issuing", pair_ready, !v.hold);
			@(negedge clk);
			check_retire("retire a", retire_valid_a, v.addr_a != '0,
				retire_addr_a, v.addr_a, retire_data_a, v.data_a);
			check_retire("retire b", retire_valid_b, !v.hold && v.addr_b != '0,
				retire_addr_b, v.addr_b, retire_data_b, v.data_b);
			@(negedge clk);
			check_retire("held retire a", retire_valid_a, v.hold && v.addr_b != '0,
				retire_addr_a, v.addr_b, retire_data_a, v.data_b);
			check_flag("idle retire b", retire_valid_b, 1'b0);
		end
	endtask

	initial
	begin
		arst_n = 1'b0;
		pair_valid = 1'b0;
		inst_a = dual_pkg::nop_word;
		inst_b = dual_pkg::nop_word;
		for (idx = 0; idx < dual_pkg::reg_count; idx++)
			ref_regs[idx] = '0;
		build_table();
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_flag("pair_ready after reset", pair_ready, 1'b1);
		check_flag("retire_valid_a after reset", retire_valid_a, 1'b0);
		check_flag("retire_valid_b after reset", retire_valid_b, 1'b0);
		for (idx = 0; idx < directed_count && timeout_count == 0; idx++)
		begin
			apply_pair(directed[idx]);
			commit_expected(directed[idx]);
		end
		for (idx = 0; idx < random_count && timeout_count == 0; idx++)
		begin
			random_pair(vec);
			apply_pair(vec);
		end
		$display("checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
			check_count, error_count, timeout_count, dut0.checks0.fail_count);
		if (error_count == 0 && timeout_count == 0 && dut0.checks0.fail_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* sim.f */
source/dual_pkg.sv
source/issue_if.sv
source/inst_decoder.sv
source/gpr_file.sv
source/pair_issue.sv
source/alu_lane.sv
source/dual_issue_core.sv
verification/dual_issue_assert.sv
verification/tb_dual_issue.sv

/* Bender.yml */
package:
  name: dual_issue_core

sources:
  - source/dual_pkg.sv
  - source/issue_if.sv
  - source/inst_decoder.sv
  - source/gpr_file.sv
  - source/pair_issue.sv
  - source/alu_lane.sv
  - source/dual_issue_core.sv
  - target: test
    files:
      - verification/dual_issue_assert.sv
      - verification/tb_dual_issue.sv
